// File: cpu6502_pkg.sv
/*
  cpu6502 shared definitions
  Bus widths, reset vector addresses, opcode encodings and the
  enumerated control types passed between sequencer, decoder and datapath
*/
`default_nettype none

package cpu6502_pkg;

  // --------------------------------------------------------------------------
  // Widths and vectors
  // --------------------------------------------------------------------------
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  localparam addr_t RESET_VEC_LO = 16'hFFFC;
  localparam addr_t RESET_VEC_HI = 16'hFFFD;

  // --------------------------------------------------------------------------
  // Opcodes, standard 6502 encodings
  // --------------------------------------------------------------------------
  // Immediate loads
  localparam data_t LDA_IMM = 8'hA9;
  localparam data_t LDX_IMM = 8'hA2;
  localparam data_t LDY_IMM = 8'hA0;
  // Implied
  localparam data_t CLC_IMP = 8'h18;
  localparam data_t SEC_IMP = 8'h38;
  localparam data_t NOP_IMP = 8'hEA;
  // Absolute loads and stores
  localparam data_t LDA_ABS = 8'hAD;
  localparam data_t LDX_ABS = 8'hAE;
  localparam data_t LDY_ABS = 8'hAC;
  localparam data_t STA_ABS = 8'h8D;
  localparam data_t STX_ABS = 8'h8E;
  localparam data_t STY_ABS = 8'h8C;
  // Absolute ALU group
  localparam data_t ADC_ABS = 8'h6D;
  localparam data_t SBC_ABS = 8'hED;
  localparam data_t AND_ABS = 8'h2D;
  localparam data_t ORA_ABS = 8'h0D;
  localparam data_t EOR_ABS = 8'h4D;
  localparam data_t CMP_ABS = 8'hCD;
  // Control flow
  localparam data_t JMP_ABS = 8'h4C;

  // --------------------------------------------------------------------------
  // Control types
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_RESET, ST_VEC_LO, ST_VEC_HI, ST_FETCH,
    ST_DECODE, ST_ABS_LO, ST_ABS_HI, ST_HALT
  } cpu_state_e;

  // Five decoded paths, so three bits
  typedef enum logic [2:0] {
    MODE_IMPLIED, MODE_IMMEDIATE, MODE_ABSOLUTE, MODE_JUMP, MODE_INVALID
  } addr_mode_e;

  typedef enum logic [2:0] {
    ALU_ADC, ALU_SBC, ALU_AND, ALU_ORA, ALU_EOR, ALU_CMP, ALU_NONE
  } alu_op_e;

  typedef enum logic [1:0] {REG_NONE, REG_A, REG_X, REG_Y} reg_sel_e;

  typedef enum logic [1:0] {CARRY_KEEP, CARRY_CLEAR, CARRY_SET} carry_op_e;

endpackage

`default_nettype wire

// File: cpu6502_alu.sv
/*
  cpu6502 ALU
  Combinational 8-bit add with carry, subtract with borrow, compare
  and bitwise logic, with carry out
*/
`timescale 1ns/1ns
`default_nettype none

module cpu6502_alu (
  input  cpu6502_pkg::alu_op_e op,
  input  cpu6502_pkg::data_t   a,
  input  cpu6502_pkg::data_t   b,
  input  logic                 carry_in,
  output cpu6502_pkg::data_t   result,
  output logic                 carry_out
);

  cpu6502_pkg::data_t b_eff;
  logic               cin_eff;
  logic [8:0]         sum;

  // Adder operand shaping
  always_comb begin
    b_eff   = b;
    cin_eff = carry_in;
    case (op)
      // Subtract as add of inverted operand, clear carry is a borrow
      cpu6502_pkg::ALU_SBC: b_eff = ~b;
      cpu6502_pkg::ALU_CMP: begin
        b_eff   = ~b;
        cin_eff = 1'b1;
      end
      default: ;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, b_eff} + {8'h00, cin_eff};

  // Result select
  always_comb begin
    result    = sum[7:0];
    carry_out = sum[8];
    case (op)
      cpu6502_pkg::ALU_AND: result = a & b;
      cpu6502_pkg::ALU_ORA: result = a | b;
      cpu6502_pkg::ALU_EOR: result = a ^ b;
      cpu6502_pkg::ALU_NONE: result = a;
      default: ;
    endcase
    // Logic ops leave carry alone
    if (op inside {cpu6502_pkg::ALU_AND, cpu6502_pkg::ALU_ORA,
                   cpu6502_pkg::ALU_EOR, cpu6502_pkg::ALU_NONE}) begin
      carry_out = carry_in;
    end
  end

endmodule

`default_nettype wire

// File: cpu6502_decoder.sv
/*
  cpu6502 instruction decoder
  Opcode table from the instruction register to addressing path,
  ALU function, register select, store flag and carry action
*/
`timescale 1ns/1ns
`default_nettype none

module cpu6502_decoder (
  input  cpu6502_pkg::data_t       ir,
  output cpu6502_pkg::addr_mode_e  mode,
  output cpu6502_pkg::alu_op_e     alu_op,
  output cpu6502_pkg::reg_sel_e    reg_sel,
  output logic                     is_store,
  output cpu6502_pkg::carry_op_e   carry_op
);

  always_comb begin
    // Anything not listed halts the core
    mode     = cpu6502_pkg::MODE_INVALID;
    alu_op   = cpu6502_pkg::ALU_NONE;
    reg_sel  = cpu6502_pkg::REG_NONE;
    is_store = 1'b0;
    carry_op = cpu6502_pkg::CARRY_KEEP;

    case (ir)
      // ----------------------------------------------------------------------
      // Two-cycle group
      // ----------------------------------------------------------------------
      cpu6502_pkg::LDA_IMM: begin
        mode    = cpu6502_pkg::MODE_IMMEDIATE;
        reg_sel = cpu6502_pkg::REG_A;
      end
      cpu6502_pkg::LDX_IMM: begin
        mode    = cpu6502_pkg::MODE_IMMEDIATE;
        reg_sel = cpu6502_pkg::REG_X;
      end
      cpu6502_pkg::LDY_IMM: begin
        mode    = cpu6502_pkg::MODE_IMMEDIATE;
        reg_sel = cpu6502_pkg::REG_Y;
      end
      cpu6502_pkg::CLC_IMP: begin
        mode     = cpu6502_pkg::MODE_IMPLIED;
        carry_op = cpu6502_pkg::CARRY_CLEAR;
      end
      cpu6502_pkg::SEC_IMP: begin
        mode     = cpu6502_pkg::MODE_IMPLIED;
        carry_op = cpu6502_pkg::CARRY_SET;
      end
      cpu6502_pkg::NOP_IMP: mode = cpu6502_pkg::MODE_IMPLIED;

      // ----------------------------------------------------------------------
      // Absolute group
      // ----------------------------------------------------------------------
      cpu6502_pkg::LDA_ABS,
      cpu6502_pkg::STA_ABS: begin
        mode     = cpu6502_pkg::MODE_ABSOLUTE;
        reg_sel  = cpu6502_pkg::REG_A;
        is_store = (ir == cpu6502_pkg::STA_ABS);
      end
      cpu6502_pkg::LDX_ABS,
      cpu6502_pkg::STX_ABS: begin
        mode     = cpu6502_pkg::MODE_ABSOLUTE;
        reg_sel  = cpu6502_pkg::REG_X;
        is_store = (ir == cpu6502_pkg::STX_ABS);
      end
      cpu6502_pkg::LDY_ABS,
      cpu6502_pkg::STY_ABS: begin
        mode     = cpu6502_pkg::MODE_ABSOLUTE;
        reg_sel  = cpu6502_pkg::REG_Y;
        is_store = (ir == cpu6502_pkg::STY_ABS);
      end
      // ALU ops always target A, so no register select
      cpu6502_pkg::ADC_ABS: begin
        mode   = cpu6502_pkg::MODE_ABSOLUTE;
        alu_op = cpu6502_pkg::ALU_ADC;
      end
      cpu6502_pkg::SBC_ABS: begin
        mode   = cpu6502_pkg::MODE_ABSOLUTE;
        alu_op = cpu6502_pkg::ALU_SBC;
      end
      cpu6502_pkg::AND_ABS: begin
        mode   = cpu6502_pkg::MODE_ABSOLUTE;
        alu_op = cpu6502_pkg::ALU_AND;
      end
      cpu6502_pkg::ORA_ABS: begin
        mode   = cpu6502_pkg::MODE_ABSOLUTE;
        alu_op = cpu6502_pkg::ALU_ORA;
      end
      cpu6502_pkg::EOR_ABS: begin
        mode   = cpu6502_pkg::MODE_ABSOLUTE;
        alu_op = cpu6502_pkg::ALU_EOR;
      end
      cpu6502_pkg::CMP_ABS: begin
        mode   = cpu6502_pkg::MODE_ABSOLUTE;
        alu_op = cpu6502_pkg::ALU_CMP;
      end
      cpu6502_pkg::JMP_ABS: mode = cpu6502_pkg::MODE_JUMP;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: cpu6502_sequencer.sv
/*
  cpu6502 sequencer
  Instruction FSM with program counter, instruction register and
  operand latch; drives the registered bus address and write strobe
*/
`timescale 1ns/1ns
`default_nettype none

module cpu6502_sequencer (
  input  logic                     clk,
  input  logic                     resetn,
  input  cpu6502_pkg::data_t       rd_data,
  input  cpu6502_pkg::addr_mode_e  mode,
  input  logic                     is_store,
  output cpu6502_pkg::cpu_state_e  state,
  output cpu6502_pkg::data_t       ir,
  output cpu6502_pkg::addr_t       address,
  output logic                     wr_enable,
  output logic                     halted
);

  // Start of the current instruction
  cpu6502_pkg::addr_t pc;
  // Low operand byte, also the low reset vector byte
  cpu6502_pkg::data_t op_lo;
  cpu6502_pkg::addr_t target;

  assign target = {rd_data, op_lo};
  assign halted = (state == cpu6502_pkg::ST_HALT);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= cpu6502_pkg::ST_RESET;
      address   <= cpu6502_pkg::RESET_VEC_LO;
      wr_enable <= 1'b0;
    end else begin
      wr_enable <= 1'b0;
      case (state)
        cpu6502_pkg::ST_RESET: state <= cpu6502_pkg::ST_VEC_LO;
        cpu6502_pkg::ST_VEC_LO: begin
          state   <= cpu6502_pkg::ST_VEC_HI;
          op_lo   <= rd_data;
          address <= cpu6502_pkg::RESET_VEC_HI;
        end
        cpu6502_pkg::ST_VEC_HI: begin
          state   <= cpu6502_pkg::ST_FETCH;
          pc      <= target;
          address <= target;
        end
        cpu6502_pkg::ST_FETCH: begin
          state   <= cpu6502_pkg::ST_DECODE;
          ir      <= rd_data;
          address <= pc + 16'd1;
        end
        cpu6502_pkg::ST_DECODE: begin
          // First operand byte on the bus now
          op_lo <= rd_data;
          case (mode)
            cpu6502_pkg::MODE_IMPLIED: begin
              state   <= cpu6502_pkg::ST_FETCH;
              pc      <= pc + 16'd1;
              address <= pc + 16'd1;
            end
            cpu6502_pkg::MODE_IMMEDIATE: begin
              state   <= cpu6502_pkg::ST_FETCH;
              pc      <= pc + 16'd2;
              address <= pc + 16'd2;
            end
            cpu6502_pkg::MODE_ABSOLUTE,
            cpu6502_pkg::MODE_JUMP: begin
              state   <= cpu6502_pkg::ST_ABS_LO;
              address <= pc + 16'd2;
            end
            // Unknown opcode, address left where it is
            default: state <= cpu6502_pkg::ST_HALT;
          endcase
        end
        cpu6502_pkg::ST_ABS_LO: begin
          address <= target;
          if (mode == cpu6502_pkg::MODE_JUMP) begin
            state <= cpu6502_pkg::ST_FETCH;
            pc    <= target;
          end else begin
            // Store strobe lines up with the operand address
            state     <= cpu6502_pkg::ST_ABS_HI;
            wr_enable <= is_store;
          end
        end
        cpu6502_pkg::ST_ABS_HI: begin
          state   <= cpu6502_pkg::ST_FETCH;
          pc      <= pc + 16'd3;
          address <= pc + 16'd3;
        end
        // Halt holds everything until reset
        default: state <= cpu6502_pkg::ST_HALT;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: cpu6502_datapath.sv
/*
  cpu6502 datapath
  A, X and Y registers and the carry flag, ALU hookup,
  load and ALU write-back, and store data capture
*/
`timescale 1ns/1ns
`default_nettype none

module cpu6502_datapath (
  input  logic                     clk,
  input  logic                     resetn,
  input  cpu6502_pkg::cpu_state_e  state,
  input  cpu6502_pkg::data_t       rd_data,
  input  cpu6502_pkg::alu_op_e     alu_op,
  input  cpu6502_pkg::reg_sel_e    reg_sel,
  input  logic                     is_store,
  input  cpu6502_pkg::carry_op_e   carry_op,
  output cpu6502_pkg::data_t       wr_data
);

  cpu6502_pkg::data_t reg_a;
  cpu6502_pkg::data_t reg_x;
  cpu6502_pkg::data_t reg_y;
  logic               carry;

  cpu6502_pkg::data_t alu_result;
  logic               alu_carry;
  cpu6502_pkg::data_t sel_data;
  logic               is_load;
  logic               load_en;
  logic               alu_en;

  // --------------------------------------------------------------------------
  // Control decode
  // --------------------------------------------------------------------------
  assign is_load = (reg_sel != cpu6502_pkg::REG_NONE) && !is_store;

  // Immediate data lands in DECODE
  // Absolute loads also catch the address byte here and get the real
  // memory byte in ABS_HI
  assign load_en = is_load && (state == cpu6502_pkg::ST_DECODE ||
                               state == cpu6502_pkg::ST_ABS_HI);
  assign alu_en  = (alu_op != cpu6502_pkg::ALU_NONE) &&
                   (state == cpu6502_pkg::ST_ABS_HI);

  // Register read for stores
  always_comb begin
    case (reg_sel)
      cpu6502_pkg::REG_A: sel_data = reg_a;
      cpu6502_pkg::REG_X: sel_data = reg_x;
      cpu6502_pkg::REG_Y: sel_data = reg_y;
      default:            sel_data = 8'h00;
    endcase
  end

  // Accumulator against memory operand
  cpu6502_alu u_alu (
    .op        (alu_op),
    .a         (reg_a),
    .b         (rd_data),
    .carry_in  (carry),
    .result    (alu_result),
    .carry_out (alu_carry)
  );

  // --------------------------------------------------------------------------
  // Register file and carry
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      reg_a <= 8'h00;
      reg_x <= 8'h00;
      reg_y <= 8'h00;
      carry <= 1'b0;
    end else begin
      if (load_en) begin
        case (reg_sel)
          cpu6502_pkg::REG_A: reg_a <= rd_data;
          cpu6502_pkg::REG_X: reg_x <= rd_data;
          cpu6502_pkg::REG_Y: reg_y <= rd_data;
          default: ;
        endcase
      end
      // CLC and SEC
      if (state == cpu6502_pkg::ST_DECODE) begin
        if (carry_op == cpu6502_pkg::CARRY_CLEAR) begin
          carry <= 1'b0;
        end else if (carry_op == cpu6502_pkg::CARRY_SET) begin
          carry <= 1'b1;
        end
      end
      // ALU commit, CMP only touches carry
      if (alu_en) begin
        carry <= alu_carry;
        if (alu_op != cpu6502_pkg::ALU_CMP) begin
          reg_a <= alu_result;
        end
      end
    end
  end

  // Store data held across ABS_HI
  always_ff @(posedge clk) begin
    if (state == cpu6502_pkg::ST_ABS_LO && is_store) begin
      wr_data <= sel_data;
    end
  end

endmodule

`default_nettype wire

// File: cpu6502_top.sv
/*
  cpu6502 core top level
  Sequencer, decoder and datapath on a fixed-latency byte memory bus
*/
`timescale 1ns/1ns
`default_nettype none

module cpu6502_top (
  input  logic               clk,
  input  logic               resetn,
  input  cpu6502_pkg::data_t rd_data,
  output cpu6502_pkg::addr_t address,
  output cpu6502_pkg::data_t wr_data,
  output logic               wr_enable,
  output logic               halted
);

  cpu6502_pkg::cpu_state_e state;
  cpu6502_pkg::data_t      ir;
  cpu6502_pkg::addr_mode_e mode;
  cpu6502_pkg::alu_op_e    alu_op;
  cpu6502_pkg::reg_sel_e   reg_sel;
  logic                    is_store;
  cpu6502_pkg::carry_op_e  carry_op;

  // Control flow and bus timing
  cpu6502_sequencer u_sequencer (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .mode      (mode),
    .is_store  (is_store),
    .state     (state),
    .ir        (ir),
    .address   (address),
    .wr_enable (wr_enable),
    .halted    (halted)
  );

  cpu6502_decoder u_decoder (
    .ir       (ir),
    .mode     (mode),
    .alu_op   (alu_op),
    .reg_sel  (reg_sel),
    .is_store (is_store),
    .carry_op (carry_op)
  );

  // Architectural registers
  cpu6502_datapath u_datapath (
    .clk      (clk),
    .resetn   (resetn),
    .state    (state),
    .rd_data  (rd_data),
    .alu_op   (alu_op),
    .reg_sel  (reg_sel),
    .is_store (is_store),
    .carry_op (carry_op),
    .wr_data  (wr_data)
  );

endmodule

`default_nettype wire

// File: cpu6502_props.sv
/*
  cpu6502 bus properties
  Bound to the core top level; checks the reset address sequence,
  single-cycle write strobes and the halt state
*/
`timescale 1ns/1ns
`default_nettype none

module cpu6502_props (
  input logic               clk,
  input logic               resetn,
  input cpu6502_pkg::addr_t address,
  input logic               wr_enable,
  input logic               halted
);

  // Cycles since reset release, saturating
  logic [1:0] since_reset;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      since_reset <= 2'd0;
    end else if (since_reset != 2'd3) begin
      since_reset <= since_reset + 2'd1;
    end
  end

  // --------------------------------------------------------------------------
  // Reset and vector fetch
  // --------------------------------------------------------------------------
  a_reset_state: assert property (@(posedge clk)
    !resetn |=> (address == cpu6502_pkg::RESET_VEC_LO) && !wr_enable && !halted)
    else $error("bus not in its reset state after a reset cycle");

  // ST_RESET then ST_VEC_LO both sit on the low vector byte
  a_vec_lo: assert property (@(posedge clk) disable iff (!resetn)
    since_reset <= 2'd1 |-> address == cpu6502_pkg::RESET_VEC_LO)
    else $error("low vector byte not addressed after reset");

  a_vec_hi: assert property (@(posedge clk) disable iff (!resetn)
    since_reset == 2'd2 |-> address == cpu6502_pkg::RESET_VEC_HI)
    else $error("high vector byte not addressed after reset");

  // --------------------------------------------------------------------------
  // Write strobe and halt
  // --------------------------------------------------------------------------
  a_wr_single: assert property (@(posedge clk) disable iff (!resetn)
    wr_enable |=> !wr_enable)
    else $error("write strobe high for two cycles in a row");

  a_halt_hold: assert property (@(posedge clk) disable iff (!resetn)
    halted |=> $stable(address) && !wr_enable)
    else $error("bus activity while halted");

  a_halt_sticky: assert property (@(posedge clk) disable iff (!resetn)
    halted |=> halted)
    else $error("halted dropped without reset");

endmodule

bind cpu6502_top cpu6502_props u_props (
  .clk       (clk),
  .resetn    (resetn),
  .address   (address),
  .wr_enable (wr_enable),
  .halted    (halted)
);

`default_nettype wire

// File: tb_cpu6502.sv
/*
  cpu6502 testbench
  Assembles a random program into a 64 KB memory model, runs the core
  from reset to a halting opcode and checks each write against a
  reference model of A, X, Y and carry
*/
`timescale 1ns/1ns
`default_nettype none

module tb_cpu6502;

  // About 80 instructions of at most 4 cycles, plus reset, well under the limit
  localparam int          MAX_CYCLES = 2000;
  localparam int          ROUNDS     = 2;
  localparam logic [15:0] PROG_START = 16'h0200;
  // Never a legal store target
  localparam logic [15:0] DEAD_ADDR  = 16'h7FFF;

  logic               clk;
  logic               resetn;
  cpu6502_pkg::data_t rd_data;
  cpu6502_pkg::addr_t address;
  cpu6502_pkg::data_t wr_data;
  logic               wr_enable;
  logic               halted;

  logic [7:0]  mem [0:65535];
  logic [31:0] seed;
  int          cycles;

  // Assembler pointers
  logic [15:0] pc_asm;
  logic [15:0] data_ptr;
  logic [15:0] out_ptr;
  // Location of the halting opcode
  logic [15:0] halt_pc;
  // Reference model
  logic [7:0]  m_a;
  logic [7:0]  m_x;
  logic [7:0]  m_y;
  logic        m_c;

  // Expected writes, in bus order
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  string       exp_name [$];

  cpu6502_top dut (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .halted    (halted)
  );

  // --------------------------------------------------------------------------
  // Memory model, async read and write at the rising edge
  // --------------------------------------------------------------------------
  assign rd_data = mem[address];

  always @(posedge clk) begin
    if (wr_enable) begin
      mem[address] <= wr_data;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Error reporting
  // --------------------------------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input logic [15:0] expected,
                                 input logic [15:0] actual);
    stop_on_error($sformatf("ERROR %s: expected %h, actual %h", test, expected, actual));
  endtask

  function automatic logic [7:0] rand_byte();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[23:16];
  endfunction

  // --------------------------------------------------------------------------
  // Assembler with model update
  // --------------------------------------------------------------------------
  task automatic emit_byte(input logic [7:0] b);
    mem[pc_asm] <= b;
    pc_asm = pc_asm + 16'd1;
  endtask

  // Opcode then little-endian operand
  task automatic emit_abs(input logic [7:0] op, input logic [15:0] a);
    emit_byte(op);
    emit_byte(a[7:0]);
    emit_byte(a[15:8]);
  endtask

  task automatic emit_implied(input logic [7:0] op);
    emit_byte(op);
    if (op == cpu6502_pkg::CLC_IMP) begin
      m_c = 1'b0;
    end else if (op == cpu6502_pkg::SEC_IMP) begin
      m_c = 1'b1;
    end
  endtask

  task automatic load_imm(input logic [7:0] op, input logic [7:0] v);
    emit_byte(op);
    emit_byte(v);
    case (op)
      cpu6502_pkg::LDA_IMM: m_a = v;
      cpu6502_pkg::LDX_IMM: m_x = v;
      default:              m_y = v;
    endcase
  endtask

  // Loads and ALU ops, operand byte placed in the data area
  task automatic read_abs(input logic [7:0] op, input logic [7:0] m);
    int total;
    mem[data_ptr] <= m;
    emit_abs(op, data_ptr);
    data_ptr = data_ptr + 16'd1;
    case (op)
      cpu6502_pkg::LDA_ABS: m_a = m;
      cpu6502_pkg::LDX_ABS: m_x = m;
      cpu6502_pkg::LDY_ABS: m_y = m;
      cpu6502_pkg::ADC_ABS: begin
        total = int'(m_a) + int'(m) + int'(m_c);
        m_a   = total[7:0];
        m_c   = (total > 255);
      end
      cpu6502_pkg::SBC_ABS: begin
        // Borrow is the inverse of carry on the 6502
        total = int'(m_a) - int'(m) - (m_c ? 0 : 1);
        m_a   = total[7:0];
        m_c   = (total >= 0);
      end
      cpu6502_pkg::AND_ABS: m_a = m_a & m;
      cpu6502_pkg::ORA_ABS: m_a = m_a | m;
      cpu6502_pkg::EOR_ABS: m_a = m_a ^ m;
      default:              m_c = (m_a >= m);
    endcase
  endtask

  task automatic store_abs(input logic [7:0] op, input string test);
    emit_abs(op, out_ptr);
    exp_addr.push_back(out_ptr);
    exp_name.push_back(test);
    case (op)
      cpu6502_pkg::STA_ABS: exp_data.push_back(m_a);
      cpu6502_pkg::STX_ABS: exp_data.push_back(m_x);
      default:              exp_data.push_back(m_y);
    endcase
    out_ptr = out_ptr + 16'd1;
  endtask

  // JMP with a store behind it that must never execute
  task automatic jump_over_store(input logic [15:0] target);
    emit_abs(cpu6502_pkg::JMP_ABS, target);
    emit_abs(cpu6502_pkg::STA_ABS, DEAD_ADDR);
    pc_asm = target;
  endtask

  task automatic build_program();
    logic [15:0] a;
    logic [15:0] jump_to;
    logic [7:0]  v;
    // Background fill over the whole address space
    a = 16'h0000;
    do begin
      mem[a] <= a[7:0] ^ a[15:8] ^ 8'h5A;
      a = a + 16'd1;
    end while (a != 16'h0000);
    mem[cpu6502_pkg::RESET_VEC_LO] <= PROG_START[7:0];
    mem[cpu6502_pkg::RESET_VEC_HI] <= PROG_START[15:8];
    pc_asm   = PROG_START;
    data_ptr = 16'h3000;
    out_ptr  = 16'h4000;
    jump_to  = 16'h5000;
    m_a = 8'h00;
    m_x = 8'h00;
    m_y = 8'h00;
    m_c = 1'b0;
    repeat (ROUNDS) begin
      // Loads and stores
      load_imm(cpu6502_pkg::LDA_IMM, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "lda_imm");
      load_imm(cpu6502_pkg::LDX_IMM, rand_byte());
      store_abs(cpu6502_pkg::STX_ABS, "ldx_imm");
      load_imm(cpu6502_pkg::LDY_IMM, rand_byte());
      store_abs(cpu6502_pkg::STY_ABS, "ldy_imm");
      read_abs(cpu6502_pkg::LDA_ABS, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "lda_abs");
      read_abs(cpu6502_pkg::LDX_ABS, rand_byte());
      store_abs(cpu6502_pkg::STX_ABS, "ldx_abs");
      read_abs(cpu6502_pkg::LDY_ABS, rand_byte());
      store_abs(cpu6502_pkg::STY_ABS, "ldy_abs");
      // Arithmetic with carry
      emit_implied(cpu6502_pkg::CLC_IMP);
      load_imm(cpu6502_pkg::LDA_IMM, rand_byte());
      read_abs(cpu6502_pkg::ADC_ABS, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "clc_adc");
      emit_implied(cpu6502_pkg::SEC_IMP);
      load_imm(cpu6502_pkg::LDA_IMM, rand_byte());
      read_abs(cpu6502_pkg::SBC_ABS, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "sec_sbc");
      emit_implied(cpu6502_pkg::SEC_IMP);
      load_imm(cpu6502_pkg::LDA_IMM, rand_byte());
      read_abs(cpu6502_pkg::ADC_ABS, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "sec_adc");
      // Logic group
      load_imm(cpu6502_pkg::LDA_IMM, rand_byte());
      read_abs(cpu6502_pkg::AND_ABS, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "and_abs");
      read_abs(cpu6502_pkg::ORA_ABS, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "ora_abs");
      read_abs(cpu6502_pkg::EOR_ABS, rand_byte());
      store_abs(cpu6502_pkg::STA_ABS, "eor_abs");
      // Compare, carry made visible by adding zero
      v = (rand_byte() & 8'h7F) | 8'h10;
      load_imm(cpu6502_pkg::LDA_IMM, v);
      read_abs(cpu6502_pkg::CMP_ABS, v + 8'd1 + (rand_byte() & 8'h3F));
      read_abs(cpu6502_pkg::ADC_ABS, 8'h00);
      store_abs(cpu6502_pkg::STA_ABS, "cmp_larger");
      read_abs(cpu6502_pkg::CMP_ABS, v >> 1);
      read_abs(cpu6502_pkg::ADC_ABS, 8'h00);
      store_abs(cpu6502_pkg::STA_ABS, "cmp_smaller");
      // Far jump, next round runs from the target
      jump_over_store(jump_to);
      emit_implied(cpu6502_pkg::NOP_IMP);
      jump_to = jump_to + 16'h1000;
    end
    // Unknown opcode ends the program
    halt_pc = pc_asm;
    emit_byte(8'h02);
  endtask

  // --------------------------------------------------------------------------
  // Write checker and cycle limit, sampled mid-cycle
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (resetn) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
        stop_on_error("Timeout: the core did not halt within the cycle limit");
      end
      if (wr_enable === 1'b1) begin
        assert (exp_addr.size() != 0)
          else stop_on_error("A write happened after all expected writes were seen");
        assert (address == exp_addr[0])
          else report_mismatch({exp_name[0], " address"}, exp_addr[0], address);
        assert (wr_data == exp_data[0])
          else report_mismatch({exp_name[0], " data"}, {8'h00, exp_data[0]},
                               {8'h00, wr_data});
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_name.pop_front());
      end
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    resetn = 1'b0;
    cycles = 0;
    seed   = 32'h2d98;
    build_program();
    repeat (2) @(negedge clk);
    resetn = 1'b1;
    // Two vector reads, then the first fetch
    @(negedge clk);
    assert (address == cpu6502_pkg::RESET_VEC_LO)
      else report_mismatch("reset_vector", cpu6502_pkg::RESET_VEC_LO, address);
    @(negedge clk);
    assert (address == cpu6502_pkg::RESET_VEC_HI)
      else report_mismatch("reset_vector", cpu6502_pkg::RESET_VEC_HI, address);
    @(negedge clk);
    assert (address == PROG_START)
      else report_mismatch("reset_vector", PROG_START, address);
    while (halted !== 1'b1) @(negedge clk);
    // Address frozen on the byte after the halting opcode
    repeat (4) begin
      assert (address == halt_pc + 16'd1)
        else report_mismatch("halt_address", halt_pc + 16'd1, address);
      @(negedge clk);
    end
    if (exp_addr.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("Core halted with %0d expected writes never seen", exp_addr.size());
      $display("*** TEST FAILED ***");
      $fatal(1, "missing writes");
    end
  end

endmodule

`default_nettype wire

// File: cpu6502.f
cpu6502_pkg.sv
cpu6502_alu.sv
cpu6502_decoder.sv
cpu6502_sequencer.sv
cpu6502_datapath.sv
cpu6502_top.sv
cpu6502_props.sv
tb_cpu6502.sv

// File: Makefile
# Verilator build and run for the cpu6502 core and its testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_cpu6502
FILELIST  ?= cpu6502.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** TEST PASSED ***

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line in the log
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
